// ==== trig_defines.svh ====
// sizes shared by packages and RTL; lane grouping assumes 40 lanes in groups of 10 alternating channel 0/1
`ifndef TRIG_DEFINES_SVH
`define TRIG_DEFINES_SVH

// digitizer word layout
`define NUM_LANES        40   // samples delivered per clklvds cycle
`define LANES_PER_GROUP  10   // lanes per channel group, groups alternate ch0/ch1
`define SAMPLE_W         12   // signed adc sample width

// acquisition memory
`define ADDR_W           10   // sample RAM depth is 2**ADDR_W words

// configuration widths
`define LEN_W            16   // pre and post trigger lengths, in RAM writes
`define CNT_W            8    // tot and holdoff counters, saturate at all ones
`define DS_W             5    // downsample exponent, write every 2**ds cycles

`endif

// ==== sample_pkg.sv ====
// sample data types; lane i sits at bus index i, lane 0 in the low bits
package sample_pkg;

`include "trig_defines.svh"

   // one adc conversion, two's complement
   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   // all lanes of one clklvds cycle
   // lanes 0-9 and 20-29 are channel 0, lanes 10-19 and 30-39 are channel 1
   typedef sample_t [`NUM_LANES-1:0] sample_bus_t;

   // sample RAM write address, wraps modulo depth
   typedef logic [`ADDR_W-1:0] addr_t;

endpackage

// ==== acq_pkg.sv ====
// acquisition control types; trigger codes other than the listed ones act as no trigger
package acq_pkg;

`include "trig_defines.svh"

   // trigger type code as written by the host
   typedef enum logic [7:0] {
      trig_none    = 8'd0,   // conditional triggering off
      trig_rising  = 8'd1,   // threshold edge, low then high
      trig_falling = 8'd2,   // threshold edge, high then low
      trig_auto    = 8'd4,   // fires as soon as armed
      trig_ext     = 8'd5    // sma input pulse
   } trig_type_t;

   // acquisition FSM states
   typedef enum logic [2:0] {
      st_idle,    // no writes, waiting for live and a valid type
      st_pre,     // filling pre-trigger samples
      st_armed,   // writing, waiting for a trigger
      st_post,    // writing post-trigger samples, trig out high
      st_done     // holding data until readout
   } acq_state_t;

   // pre and post trigger length in RAM writes
   typedef logic [`LEN_W-1:0] len_t;

   // time over threshold and holdoff counts
   typedef logic [`CNT_W-1:0] cnt_t;

endpackage

// ==== edge_trigger.sv ====
// samples compared signed against static thresholds; tot and holdoff count write ticks, not cycles
`timescale 1ns/100ps
`include "trig_defines.svh"

module edge_trigger (
   input  logic                    clklvds,
   input  logic                    rst_n,
   input  sample_pkg::sample_bus_t samples,
   input  sample_pkg::sample_t     lower_thresh,
   input  sample_pkg::sample_t     upper_thresh,
   input  logic                    edge_arm,      // level, high while armed for an edge type
   input  logic                    edge_rising,   // 1 rising, 0 falling
   input  logic                    dual_channel,  // 1 restricts to lanes of trig_chan
   input  logic                    trig_chan,
   input  logic                    write_tick,    // one pulse per RAM write
   input  acq_pkg::cnt_t           tot,
   input  acq_pkg::cnt_t           holdoff,
   output logic                    edge_fire      // one cycle strobe
);

   logic [`NUM_LANES-1:0] lane_sel;    // lane takes part in the trigger
   logic [`NUM_LANES-1:0] lane_below;  // lane under lower threshold
   logic [`NUM_LANES-1:0] lane_above;  // lane over upper threshold
   logic                  first_hit;   // step one condition on any selected lane
   logic                  pass;        // step two condition on any selected lane
   logic                  second_step; // step one seen, looking for the opposite side
   acq_pkg::cnt_t         holdoff_cnt; // quiet write ticks in step two
   acq_pkg::cnt_t         tot_cnt;     // passing write ticks in a row

   // per lane compares, all 40 lanes in parallel
   always_comb begin : lane_compare
      for (int i = 0; i < `NUM_LANES; i++) begin
         // group index parity gives the channel of the lane
         lane_sel[i]   = !dual_channel ||
                         ((((i / `LANES_PER_GROUP) % 2) == 1) == trig_chan);
         lane_below[i] = sample_pkg::sample_t'(samples[i]) < lower_thresh;   // signed compare
         lane_above[i] = sample_pkg::sample_t'(samples[i]) > upper_thresh;
      end
   end

   // rising edge starts below lower and ends above upper, falling the other way round
   assign first_hit = |(lane_sel & (edge_rising ? lane_below : lane_above));
   assign pass      = |(lane_sel & (edge_rising ? lane_above : lane_below));

   always_ff @(posedge clklvds) begin
      if (!rst_n || !edge_arm) begin     // disarming wipes the detector
         second_step <= 1'b0;
         holdoff_cnt <= '0;
         tot_cnt     <= '0;
         edge_fire   <= 1'b0;
      end
      else begin
         edge_fire <= 1'b0;              // default, strobe lasts one cycle
         if (!second_step) begin
            if (first_hit) begin
               second_step <= 1'b1;      // first threshold crossed somewhere in this word
            end
         end
         else if (pass) begin
            if (holdoff_cnt < holdoff) begin
               // not quiet long enough before this pass, start over
               second_step <= 1'b0;
               holdoff_cnt <= '0;
            end
            else if (tot_cnt >= tot) begin
               edge_fire   <= 1'b1;      // fire, and go back to step one so it stays a strobe
               second_step <= 1'b0;
               holdoff_cnt <= '0;
               tot_cnt     <= '0;
            end
            else if (write_tick && tot_cnt != '1) begin
               tot_cnt <= tot_cnt + 1'b1; // still over, one more write tick of tot
            end
         end
         else begin
            tot_cnt <= '0;               // dropped back, tot restarts
            if (write_tick && holdoff_cnt != '1) begin
               holdoff_cnt <= holdoff_cnt + 1'b1;  // quiet tick, saturates at 255
            end
         end
      end
   end

endmodule

// ==== ext_trigger.sv ====
// ext_trig_in is asynchronous; pulse width counted in clklvds cycles after two sync flops
`timescale 1ns/100ps

module ext_trigger (
   input  logic          clklvds,
   input  logic          rst_n,
   input  logic          ext_trig_in,  // sma input, any clock domain
   input  logic          ext_arm,      // level, high while armed for the ext type
   input  acq_pkg::cnt_t tot,          // minimum high width in cycles
   output logic          ext_fire      // one cycle strobe
);

   logic          sync_meta;   // first sync flop, may go metastable
   logic          sync_q;      // second sync flop, safe to use
   logic          sync_last;   // sync_q one cycle back, for the edge
   logic          rise;
   logic          seen_rise;   // a rising edge arrived while armed
   acq_pkg::cnt_t high_cnt;    // cycles the input has been high

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         sync_meta <= 1'b0;
         sync_q    <= 1'b0;
         sync_last <= 1'b0;
      end
      else begin
         sync_meta <= ext_trig_in;
         sync_q    <= sync_meta;
         sync_last <= sync_q;
      end
   end

   assign rise = sync_q && !sync_last;

   always_ff @(posedge clklvds) begin
      if (!rst_n || !ext_arm) begin
         seen_rise <= 1'b0;
         high_cnt  <= '0;
         ext_fire  <= 1'b0;
      end
      else begin
         ext_fire <= 1'b0;
         if (seen_rise && high_cnt >= tot) begin
            ext_fire  <= 1'b1;           // pulse long enough
            seen_rise <= 1'b0;           // needs a fresh edge to fire again
            high_cnt  <= '0;
         end
         else begin
            if (rise) seen_rise <= 1'b1;
            if (!sync_q) high_cnt <= '0;                            // input low, width restarts
            else if (high_cnt != '1) high_cnt <= high_cnt + 1'b1;   // saturates at 255
         end
      end
   end

endmodule

// ==== acq_sequencer.sv ====
// ram_wr is decoded from state and pacing, so it never pulses in idle or done; writes go to ram_wr_address
`timescale 1ns/100ps
`include "trig_defines.svh"

module acq_sequencer (
   input  logic                clklvds,
   input  logic                rst_n,
   input  logic                live,          // host allows a new acquisition
   input  logic                readout,       // one cycle, host has read the event
   input  acq_pkg::trig_type_t trig_type,
   input  logic [`DS_W-1:0]    downsample,    // write every 2**downsample cycles
   input  acq_pkg::len_t       pre_len,
   input  acq_pkg::len_t       post_len,
   input  acq_pkg::cnt_t       tot,           // trigger address is moved back by this
   input  logic                edge_fire,
   input  logic                ext_fire,
   output logic                edge_arm,
   output logic                edge_rising,
   output logic                ext_arm,
   output logic                ram_wr,
   output logic                trig_out,
   output logic                acq_ready,
   output sample_pkg::addr_t   ram_wr_address,
   output sample_pkg::addr_t   trig_address,
   output logic [31:0]         event_count,
   output acq_pkg::acq_state_t acq_state
);

   acq_pkg::trig_type_t cur_type;      // type captured when leaving idle
   logic [31:0]         pace_cnt;      // one-hot style pacing, bit ds set means write now
   acq_pkg::len_t       len_cnt;       // writes counted in pre or post
   acq_pkg::len_t       stage_len;     // length of the stage being counted
   logic                writing;       // states that fill the RAM
   logic                type_valid;    // trig_type is one of the known codes
   logic                type_changed;  // host changed type under us
   logic                stage_end;     // pre or post length reached this cycle
   logic                fire;          // any trigger source for the latched type
   logic                fire_now;      // trigger taken in this cycle

   assign writing   = (acq_state == acq_pkg::st_pre) || (acq_state == acq_pkg::st_armed) ||
                      (acq_state == acq_pkg::st_post);
   assign ram_wr    = writing && pace_cnt[downsample];
   assign type_valid = trig_type inside {acq_pkg::trig_rising, acq_pkg::trig_falling,
                                         acq_pkg::trig_auto, acq_pkg::trig_ext};
   assign type_changed = trig_type != cur_type;

   // detector arming follows the latched type
   assign edge_rising = cur_type == acq_pkg::trig_rising;
   assign edge_arm    = (acq_state == acq_pkg::st_armed) &&
                        (cur_type == acq_pkg::trig_rising || cur_type == acq_pkg::trig_falling);
   assign ext_arm     = (acq_state == acq_pkg::st_armed) && (cur_type == acq_pkg::trig_ext);

   assign fire     = (cur_type == acq_pkg::trig_auto) || (edge_arm && edge_fire) ||
                     (ext_arm && ext_fire);
   assign fire_now = (acq_state == acq_pkg::st_armed) && !type_changed && fire;

   // zero length ends at once, otherwise on the cycle of the last counted write
   assign stage_len = (acq_state == acq_pkg::st_pre) ? pre_len : post_len;
   assign stage_end = (len_cnt >= stage_len) || (ram_wr && len_cnt == stage_len - 1'b1);

   assign trig_out  = acq_state == acq_pkg::st_post;
   assign acq_ready = acq_state == acq_pkg::st_done;

   // write pacing and address
   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         pace_cnt       <= 32'd1;
         ram_wr_address <= '0;
      end
      else if (!writing) begin
         pace_cnt <= 32'd1;            // restart so the first write lands 2**ds cycles in
      end
      else if (ram_wr) begin
         pace_cnt       <= 32'd1;
         ram_wr_address <= ram_wr_address + 1'b1;   // wraps at 1024
      end
      else begin
         pace_cnt <= pace_cnt + 1'b1;
      end
   end

   // trigger position, back by tot so it points at the start of the pulse
   always_ff @(posedge clklvds) begin
      if (fire_now) trig_address <= ram_wr_address - sample_pkg::addr_t'(tot);
   end

   // acquisition FSM
   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         acq_state   <= acq_pkg::st_idle;
         cur_type    <= acq_pkg::trig_none;
         len_cnt     <= '0;
         event_count <= '0;
      end
      else begin
         case (acq_state)
            acq_pkg::st_idle: begin
               len_cnt  <= '0;
               cur_type <= trig_type;                  // holds the value seen on the way out
               if (live && type_valid) acq_state <= acq_pkg::st_pre;
            end
            acq_pkg::st_pre: begin
               if (type_changed) begin
                  acq_state <= acq_pkg::st_idle;       // abort, nothing kept
               end
               else if (stage_end) begin
                  acq_state <= acq_pkg::st_armed;
                  len_cnt   <= '0;
               end
               else if (ram_wr) begin
                  len_cnt <= len_cnt + 1'b1;
               end
            end
            acq_pkg::st_armed: begin
               if (type_changed) acq_state <= acq_pkg::st_idle;
               else if (fire_now) acq_state <= acq_pkg::st_post;
            end
            acq_pkg::st_post: begin
               if (stage_end) begin
                  acq_state   <= acq_pkg::st_done;
                  event_count <= event_count + 1'b1;
                  len_cnt     <= '0;
               end
               else if (ram_wr) begin
                  len_cnt <= len_cnt + 1'b1;
               end
            end
            acq_pkg::st_done: begin
               if (readout) acq_state <= acq_pkg::st_idle;  // host done, rearm
            end
            default: acq_state <= acq_pkg::st_idle;
         endcase
      end
   end

endmodule

// ==== triggerer_top.sv ====
// all configuration inputs must be static or already in the clklvds domain; only ext_trig_in is synced
`timescale 1ns/100ps
`include "trig_defines.svh"

module triggerer_top (
   input  logic                    clklvds,
   input  logic                    rst_n,
   input  sample_pkg::sample_bus_t samples,
   input  sample_pkg::sample_t     lower_thresh,
   input  sample_pkg::sample_t     upper_thresh,
   input  logic                    dual_channel,
   input  logic                    trig_chan,
   input  acq_pkg::cnt_t           holdoff,
   input  logic                    ext_trig_in,   // back panel sma, asynchronous
   input  logic                    live,
   input  logic                    readout,
   input  acq_pkg::trig_type_t     trig_type,
   input  logic [`DS_W-1:0]        downsample,
   input  acq_pkg::len_t           pre_len,
   input  acq_pkg::len_t           post_len,
   input  acq_pkg::cnt_t           tot,           // shared by edge, ext and address offset
   output logic                    ram_wr,
   output sample_pkg::addr_t       ram_wr_address,
   output sample_pkg::addr_t       trig_address,
   output logic [31:0]             event_count,
   output acq_pkg::acq_state_t     acq_state,
   output logic                    trig_out,
   output logic                    acq_ready
);

   logic edge_arm;     // sequencer to edge detector
   logic edge_rising;
   logic ext_arm;      // sequencer to ext detector
   logic edge_fire;    // detectors back to sequencer
   logic ext_fire;

   edge_trigger edge_trigger_i (
      .clklvds      (clklvds),
      .rst_n        (rst_n),
      .samples      (samples),
      .lower_thresh (lower_thresh),
      .upper_thresh (upper_thresh),
      .edge_arm     (edge_arm),
      .edge_rising  (edge_rising),
      .dual_channel (dual_channel),
      .trig_chan    (trig_chan),
      .write_tick   (ram_wr),          // tot and holdoff follow the write rate
      .tot          (tot),
      .holdoff      (holdoff),
      .edge_fire    (edge_fire)
   );

   ext_trigger ext_trigger_i (
      .clklvds     (clklvds),
      .rst_n       (rst_n),
      .ext_trig_in (ext_trig_in),
      .ext_arm     (ext_arm),
      .tot         (tot),
      .ext_fire    (ext_fire)
   );

   acq_sequencer acq_sequencer_i (
      .clklvds        (clklvds),
      .rst_n          (rst_n),
      .live           (live),
      .readout        (readout),
      .trig_type      (trig_type),
      .downsample     (downsample),
      .pre_len        (pre_len),
      .post_len       (post_len),
      .tot            (tot),
      .edge_fire      (edge_fire),
      .ext_fire       (ext_fire),
      .edge_arm       (edge_arm),
      .edge_rising    (edge_rising),
      .ext_arm        (ext_arm),
      .ram_wr         (ram_wr),
      .trig_out       (trig_out),
      .acq_ready      (acq_ready),
      .ram_wr_address (ram_wr_address),
      .trig_address   (trig_address),
      .event_count    (event_count),
      .acq_state      (acq_state)
   );

endmodule

// ==== tb_triggerer.sv ====
// directed tests only; thresholds fixed at -100/100, LCG lane noise always stays strictly between them
`timescale 1ns/100ps
`include "trig_defines.svh"

module tb_triggerer;

   logic                    clklvds;
   logic                    rst_n;
   sample_pkg::sample_bus_t samples;
   sample_pkg::sample_t     lower_thresh;
   sample_pkg::sample_t     upper_thresh;
   logic                    dual_channel;
   logic                    trig_chan;
   acq_pkg::cnt_t           holdoff;
   logic                    ext_trig_in;
   logic                    live;
   logic                    readout;
   acq_pkg::trig_type_t     trig_type;
   logic [4:0]              downsample;
   acq_pkg::len_t           pre_len;
   acq_pkg::len_t           post_len;
   acq_pkg::cnt_t           tot;
   logic                    ram_wr;
   sample_pkg::addr_t       ram_wr_address;
   sample_pkg::addr_t       trig_address;
   logic [31:0]             event_count;
   acq_pkg::acq_state_t     acq_state;
   logic                    trig_out;
   logic                    acq_ready;

   int                      errors;       // wrong values
   int                      timeouts;     // waits that ran out
   int                      cycle;        // clock count read at negedge
   int                      wr_seen;      // write pulses since reset, models the write address
   logic [31:0]             lcg_state;
   logic [1:0]              force_on;     // per channel noise override
   sample_pkg::sample_t     force_level [2];

   triggerer_top triggerer_top_i (
      .clklvds        (clklvds),
      .rst_n          (rst_n),
      .samples        (samples),
      .lower_thresh   (lower_thresh),
      .upper_thresh   (upper_thresh),
      .dual_channel   (dual_channel),
      .trig_chan      (trig_chan),
      .holdoff        (holdoff),
      .ext_trig_in    (ext_trig_in),
      .live           (live),
      .readout        (readout),
      .trig_type      (trig_type),
      .downsample     (downsample),
      .pre_len        (pre_len),
      .post_len       (post_len),
      .tot            (tot),
      .ram_wr         (ram_wr),
      .ram_wr_address (ram_wr_address),
      .trig_address   (trig_address),
      .event_count    (event_count),
      .acq_state      (acq_state),
      .trig_out       (trig_out),
      .acq_ready      (acq_ready)
   );

   initial begin
      clklvds = 1'b0;
      forever #5 clklvds = ~clklvds;   // 10 ns period
   end

   initial begin
      cycle = 0;
      forever begin
         @(posedge clklvds);
         cycle <= cycle + 1;
      end
   end

   // address grows by one per write pulse, so the count mod 1024 is the expected address
   initial begin
      wr_seen = 0;
      forever begin
         @(negedge clklvds);
         if (ram_wr === 1'b1) wr_seen <= wr_seen + 1;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
      return lcg_state;
   endfunction

   // one clock of lanes with noise unless the lane's channel is overridden
   function automatic sample_pkg::sample_bus_t next_word();
      sample_pkg::sample_bus_t w;
      int ch;
      int v;
      for (int i = 0; i < `NUM_LANES; i++) begin
         ch   = (i / `LANES_PER_GROUP) % 2;                  // groups alternate ch0 and ch1
         v    = int'((lcg_next() >> 8) % 32'd199) - 99;     // -99..99
         w[i] = force_on[ch] ? force_level[ch] : sample_pkg::sample_t'(v);
      end
      return w;
   endfunction

   initial begin
      samples   = '0;
      lcg_state = 32'haca20f79;
      forever begin
         @(posedge clklvds);
         samples <= next_word();
      end
   end

   task automatic end_run();
      $display("closing: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("NO ERRORS");
      end
      else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   task automatic report_timeout(input string name, input string what);
      $display("Timeout in %s: %s", name, what);
      timeouts++;
      end_run();
   endtask

   task automatic check_addr(input string name, input sample_pkg::addr_t exp,
                             input sample_pkg::addr_t act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_state(input string name, input acq_pkg::acq_state_t exp,
                              input acq_pkg::acq_state_t act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
      end
   endtask

   task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic wait_state(input string name, input acq_pkg::acq_state_t want, input int limit);
      int n;
      n = 0;
      @(negedge clklvds);
      while (acq_state !== want && n < limit) begin
         @(negedge clklvds);
         n++;
      end
      if (acq_state !== want)
         report_timeout(name, $sformatf("acquisition did not reach %s", want.name()));
   endtask

   task automatic wait_write(input string name, output int at);
      int n;
      n = 0;
      @(negedge clklvds);
      while (!ram_wr && n < 64) begin
         @(negedge clklvds);
         n++;
      end
      if (!ram_wr) report_timeout(name, "no RAM write pulse came");
      at = cycle;
   endtask

   // state must stay armed for the whole window and only the first slip is reported
   task automatic expect_armed(input string name, input int cycles);
      int n;
      logic bad;
      bad = 1'b0;
      for (n = 0; n < cycles && !bad; n++) begin
         @(negedge clklvds);
         if (acq_state !== acq_pkg::st_armed) begin
            check_state(name, acq_pkg::st_armed, acq_state);
            bad = 1'b1;
         end
      end
   endtask

   task automatic drive_chan(input int ch, input logic on, input sample_pkg::sample_t level);
      @(posedge clklvds);
      force_on[ch]    <= on;       // lanes follow one clock later
      force_level[ch] <= level;
   endtask

   task automatic drive_pulse(input int width);
      @(posedge clklvds);
      ext_trig_in <= 1'b1;
      repeat (width) @(posedge clklvds);
      ext_trig_in <= 1'b0;
   endtask

   task automatic configure(input acq_pkg::trig_type_t t, input logic [4:0] ds,
                            input acq_pkg::len_t pre, input acq_pkg::len_t post,
                            input acq_pkg::cnt_t t_over);
      @(posedge clklvds);
      trig_type  <= t;
      downsample <= ds;
      pre_len    <= pre;
      post_len   <= post;
      tot        <= t_over;
      live       <= 1'b1;
   endtask

   // lets the event finish and reads it out so idle follows the strobe
   task automatic release_acq(input string name);
      wait_state(name, acq_pkg::st_done, 400);
      @(posedge clklvds);
      live    <= 1'b0;             // no rearm after readout
      readout <= 1'b1;
      @(posedge clklvds);
      readout <= 1'b0;
      @(negedge clklvds);
      check_state({name, " readout"}, acq_pkg::st_idle, acq_state);
   endtask

   task automatic test_reset();
      @(negedge clklvds);
      check_bit("reset ram_wr", 1'b0, ram_wr);
      check_bit("reset trig_out", 1'b0, trig_out);
      check_bit("reset acq_ready", 1'b0, acq_ready);
      check_state("reset state", acq_pkg::st_idle, acq_state);
      check_count("reset event_count", 32'd0, event_count);
      check_addr("reset ram_wr_address", 10'd0, ram_wr_address);
   endtask

   task automatic test_auto();
      int t1;
      int t2;
      int n;
      int writes;
      sample_pkg::addr_t fire_addr;
      configure(acq_pkg::trig_auto, 5'd2, 16'd3, 16'd5, 8'd7);
      wait_state("auto", acq_pkg::st_pre, 10);
      wait_write("auto", t1);
      wait_write("auto", t2);
      check_count("auto write spacing", 32'd4, t2 - t1);   // 2**2 cycles
      wait_state("auto", acq_pkg::st_armed, 40);            // fires on this cycle
      fire_addr = sample_pkg::addr_t'(wr_seen);
      check_addr("auto write address", fire_addr, ram_wr_address);
      writes    = ram_wr;
      n         = 0;
      @(negedge clklvds);
      while (!acq_ready && n < 100) begin
         writes += ram_wr;
         check_bit("auto trig_out", 1'b1, trig_out);
         @(negedge clklvds);
         n++;
      end
      if (!acq_ready) report_timeout("auto", "acq_ready did not go high");
      check_count("auto post writes", 32'd5, writes);
      check_addr("auto trig_address", sample_pkg::addr_t'(fire_addr - 10'd7), trig_address);
      check_count("auto event_count", 32'd1, event_count);   // first event since reset
      release_acq("auto");
   endtask

   task automatic test_rising_chan();
      @(posedge clklvds);
      dual_channel <= 1'b1;
      trig_chan    <= 1'b1;        // only lanes 10-19 and 30-39 count
      configure(acq_pkg::trig_rising, 5'd0, 16'd4, 16'd4, 8'd0);
      wait_state("rising", acq_pkg::st_armed, 40);
      drive_chan(0, 1'b1, -12'sd500);
      expect_armed("rising ch0 low", 4);
      drive_chan(0, 1'b1, 12'sd500);
      expect_armed("rising ch0 high", 6);
      drive_chan(0, 1'b0, 12'sd0);
      expect_armed("rising ch0 released", 10);
      drive_chan(1, 1'b1, -12'sd500);
      expect_armed("rising ch1 low", 4);
      drive_chan(1, 1'b1, 12'sd500);
      wait_state("rising ch1", acq_pkg::st_post, 20);
      drive_chan(1, 1'b0, 12'sd0);
      release_acq("rising ch1");
      @(posedge clklvds);
      dual_channel <= 1'b0;
      trig_chan    <= 1'b0;
   endtask

   task automatic test_falling_tot();
      int n;
      sample_pkg::addr_t last_addr;
      last_addr = '0;
      configure(acq_pkg::trig_falling, 5'd0, 16'd4, 16'd4, 8'd3);
      wait_state("falling", acq_pkg::st_armed, 40);
      drive_chan(0, 1'b1, 12'sd500);     // above upper for step one
      expect_armed("falling high", 3);
      drive_chan(0, 1'b1, -12'sd500);
      drive_chan(0, 1'b0, 12'sd0);       // below lower for exactly one write
      expect_armed("falling one tick", 20);
      drive_chan(0, 1'b1, 12'sd500);
      expect_armed("falling high again", 3);
      drive_chan(0, 1'b1, -12'sd500);    // held below until the trigger
      n = 0;
      @(negedge clklvds);
      while (acq_state !== acq_pkg::st_post && n < 12) begin
         last_addr = sample_pkg::addr_t'(wr_seen);   // address of the cycle before post
         @(negedge clklvds);
         n++;
      end
      if (acq_state !== acq_pkg::st_post)
         report_timeout("falling", "a ten tick pass did not trigger");
      check_addr("falling trig_address", sample_pkg::addr_t'(last_addr - 10'd3), trig_address);
      drive_chan(0, 1'b0, 12'sd0);
      release_acq("falling");
   endtask

   task automatic test_ext_width();
      configure(acq_pkg::trig_ext, 5'd1, 16'd4, 16'd20, 8'd5);
      wait_state("ext", acq_pkg::st_armed, 40);
      drive_pulse(2);
      expect_armed("ext short pulse", 20);
      drive_pulse(20);                   // post runs 40 cycles so it is still running here
      wait_state("ext long pulse", acq_pkg::st_post, 10);
      release_acq("ext");
   endtask

   task automatic test_abort();
      int n;
      configure(acq_pkg::trig_auto, 5'd0, 16'd100, 16'd4, 8'd0);
      wait_state("abort", acq_pkg::st_pre, 10);
      @(posedge clklvds);
      trig_type <= acq_pkg::trig_rising;   // type swap mid pre
      live      <= 1'b0;
      wait_state("abort", acq_pkg::st_idle, 5);
      for (n = 0; n < 20; n++) begin
         @(negedge clklvds);
         check_bit("abort ram_wr", 1'b0, ram_wr);
         check_state("abort state", acq_pkg::st_idle, acq_state);
      end
   endtask

   initial begin
      errors         = 0;
      timeouts       = 0;
      force_on       = 2'b00;
      force_level[0] = '0;
      force_level[1] = '0;
      rst_n          = 1'b0;
      lower_thresh   = -12'sd100;
      upper_thresh   = 12'sd100;
      dual_channel   = 1'b0;
      trig_chan      = 1'b0;
      holdoff        = 8'd0;     // holdoff never restarts step one
      ext_trig_in    = 1'b0;
      live           = 1'b0;
      readout        = 1'b0;
      trig_type      = acq_pkg::trig_none;
      downsample     = 5'd0;
      pre_len        = 16'd0;
      post_len       = 16'd0;
      tot            = 8'd0;
      repeat (10) @(posedge clklvds);
      rst_n <= 1'b1;
      test_reset();
      test_auto();
      test_rising_chan();
      test_falling_tot();
      test_ext_width();
      test_abort();
      end_run();
   end

endmodule

// ==== flist.f ====
+incdir+.
sample_pkg.sv
acq_pkg.sv
edge_trigger.sv
ext_trigger.sv
acq_sequencer.sv
triggerer_top.sv
tb_triggerer.sv
